// File: usbRx_defs.svh
// Timing constants of the USB full-speed receive front end, included by the RTL and the testbench
`ifndef USB_RX_DEFS_SVH
`define USB_RX_DEFS_SVH

// 48 MHz sampling of a 12 Mbit/s line
`define USB_SAMPLES_PER_BIT 4

// Phase count at which a bit is taken, close to mid-bit
`define USB_SAMPLE_PHASE 2

// Continuous SE0 for 2.5 us at 48 MHz means bus reset
`define USB_RESET_SE0_CYCLES 120

// A stuffed zero follows this many consecutive ones
`define USB_MAX_ONES 6

`endif

// File: usbRxPkg.sv
// Packed structs shared by the receive front end blocks and their testbench
package usbRxPkg;

    // Decoded line state after synchronization
    // Exactly one of se0, j and k is set for a legal line
    // invalid marks D+ and D- both high, with the other three bits clear
    typedef struct packed {
        logic se0;
        logic j;
        logic k;
        logic invalid;
    } lineState_t;

    // One sampled bit from clock recovery
    typedef struct packed {
        logic value;  // line level, J reads as 1
        logic se0;
    } rxBit_t;

    // One received byte
    // first marks the byte right after SYNC, which is the PID
    typedef struct packed {
        logic       first;
        logic [7:0] data;
    } rxByte_t;

endpackage

// File: lineSampler.sv
// Synchronizes the D+ and D- pins and registers the decoded line state for all consumers
module lineSampler
    import usbRxPkg::*;
(
    input  logic       clk48_i,
    input  logic       rstN_i,
    input  logic       dp_i,
    input  logic       dn_i,
    output lineState_t line_o
);

    logic       dpMetaQ;
    logic       dnMetaQ;
    lineState_t lineNext;

    // Decode from the first synchronizer stage, the second stage is line_o itself
    always_comb begin
        lineNext.se0     = !dpMetaQ && !dnMetaQ;
        lineNext.j       = dpMetaQ && !dnMetaQ;
        lineNext.k       = !dpMetaQ && dnMetaQ;
        lineNext.invalid = dpMetaQ && dnMetaQ;
    end

    // Both stages come out of reset showing an idle J line
    always_ff @(posedge clk48_i or negedge rstN_i) begin
        if (!rstN_i) begin
            dpMetaQ <= 1'b1;
            dnMetaQ <= 1'b0;
            line_o  <= '{se0: 1'b0, j: 1'b1, k: 1'b0, invalid: 1'b0};
        end else begin
            dpMetaQ <= dp_i;
            dnMetaQ <= dn_i;
            line_o  <= lineNext;
        end
    end

endmodule

// File: eopResetDetect.sv
// Flags end of packet and bus reset from the line state, each flag held until its acknowledge
`include "usbRx_defs.svh"

module eopResetDetect
    import usbRxPkg::*;
(
    input  logic       clk48_i,
    input  logic       rstN_i,
    input  lineState_t line_i,
    input  logic       ackEop_i,
    input  logic       ackUsbRst_i,
    output logic       eopDetect_o,  // sticky until ackEop_i
    output logic       usbRst_o      // sticky until ackUsbRst_i
);

    localparam int CountWidth = $clog2(`USB_RESET_SE0_CYCLES + 1);
    localparam logic [CountWidth-1:0] ResetCount = CountWidth'(`USB_RESET_SE0_CYCLES);

    typedef enum logic [2:0] {
        IDLE,
        FIRST_SE0,
        SECOND_SE0,
        THIRD_SE0,
        LAST_CHANCE
    } eopState_t;

    eopState_t             stateQ;
    eopState_t             stateNext;
    logic                  eopSet;
    logic [CountWidth-1:0] se0CountQ;
    logic [CountWidth-1:0] se0CountNext;
    logic                  se0;
    logic                  j;

    assign se0 = line_i.se0;
    assign j   = line_i.j;

    // Counter saturates so a long SE0 cannot wrap around
    assign se0CountNext = !se0                     ? '0 :
                          (se0CountQ == ResetCount) ? se0CountQ :
                                                      se0CountQ + CountWidth'(1);

    // Three or more SE0 cycles followed by J make an EOP
    always_comb begin
        stateNext = stateQ;
        eopSet    = 1'b0;
        unique case (stateQ)
            IDLE: begin
                if (se0) begin
                    stateNext = FIRST_SE0;
                end
            end
            FIRST_SE0: begin
                stateNext = se0 ? SECOND_SE0 : IDLE;
            end
            SECOND_SE0: begin
                stateNext = se0 ? THIRD_SE0 : IDLE;
            end
            THIRD_SE0: begin
                eopSet = j;
                if (se0) begin
                    stateNext = THIRD_SE0;
                end else if (j) begin
                    stateNext = IDLE;
                end else begin
                    // A K or invalid sample gets one more cycle to turn into J
                    stateNext = LAST_CHANCE;
                end
            end
            LAST_CHANCE: begin
                eopSet    = j;
                stateNext = IDLE;
            end
            default: begin
                stateNext = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk48_i or negedge rstN_i) begin
        if (!rstN_i) begin
            stateQ      <= IDLE;
            eopDetect_o <= 1'b0;
        end else begin
            stateQ <= stateNext;
            // Acknowledge wins over a new EOP in the same cycle
            if (ackEop_i) begin
                eopDetect_o <= 1'b0;
            end else if (eopSet) begin
                eopDetect_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk48_i or negedge rstN_i) begin
        if (!rstN_i) begin
            se0CountQ <= '0;
            usbRst_o  <= 1'b0;
        end else if (ackUsbRst_i) begin
            se0CountQ <= '0;
            usbRst_o  <= 1'b0;
        end else begin
            se0CountQ <= se0CountNext;
            if (se0CountQ == ResetCount) begin
                usbRst_o <= 1'b1;
            end
        end
    end

endmodule

// File: clockRecovery.sv
// Recovers bit timing from J/K transitions and strobes one line sample per bit
`include "usbRx_defs.svh"

module clockRecovery
    import usbRxPkg::*;
(
    input  logic       clk48_i,
    input  logic       rstN_i,
    input  lineState_t line_i,
    output logic       bitStrobe_o,
    output rxBit_t     rxBit_o
);

    localparam logic [1:0] LastPhase   = 2'(`USB_SAMPLES_PER_BIT - 1);
    localparam logic [1:0] SamplePhase = 2'(`USB_SAMPLE_PHASE);

    logic [1:0] phaseQ;
    logic [1:0] phaseNow;
    logic       lastLevelQ;
    logic       lineActive;
    logic       edgeSeen;

    // Only J and K carry a level, SE0 and invalid leave the last level alone
    assign lineActive = line_i.j || line_i.k;
    assign edgeSeen   = lineActive && (line_i.j != lastLevelQ);

    // Phase of the sample now on line_i within its bit
    // A transition marks the first sample of a new bit
    always_comb begin
        if (edgeSeen) begin
            phaseNow = 2'd0;
        end else if (phaseQ == LastPhase) begin
            phaseNow = 2'd0;
        end else begin
            phaseNow = phaseQ + 2'd1;
        end
    end

    always_ff @(posedge clk48_i or negedge rstN_i) begin
        if (!rstN_i) begin
            phaseQ      <= LastPhase;
            lastLevelQ  <= 1'b1;
            bitStrobe_o <= 1'b0;
        end else begin
            phaseQ      <= phaseNow;
            bitStrobe_o <= (phaseNow == SamplePhase);
            if (lineActive) begin
                lastLevelQ <= line_i.j;
            end
        end
    end

    // Sampled bit is only meaningful with bitStrobe_o
    always_ff @(posedge clk48_i) begin
        if (phaseNow == SamplePhase) begin
            rxBit_o.value <= line_i.j;
            rxBit_o.se0   <= line_i.se0;
        end
    end

endmodule

// File: nrziUnstuff.sv
// Decodes NRZI bits, removes stuffed zeros and flags stuffing violations
`include "usbRx_defs.svh"

module nrziUnstuff
    import usbRxPkg::*;
(
    input  logic   clk48_i,
    input  logic   rstN_i,
    input  logic   bitStrobe_i,
    input  rxBit_t rxBit_i,
    output logic   dataStrobe_o,
    output logic   dataBit_o,
    output logic   stuffError_o,
    output logic   lineIdle_o
);

    localparam logic [2:0] MaxOnes = 3'(`USB_MAX_ONES);

    logic       prevLevelQ;
    logic [2:0] onesQ;
    logic       se0SeenQ;
    logic       decoded;

    // No level change decodes as 1
    assign decoded = (rxBit_i.value == prevLevelQ);

    // lineIdle_o rises on the first J bit after SE0 and falls on the first
    // transition, so idle J does not count as a run of ones
    always_ff @(posedge clk48_i or negedge rstN_i) begin
        if (!rstN_i) begin
            prevLevelQ   <= 1'b1;
            onesQ        <= '0;
            se0SeenQ     <= 1'b0;
            lineIdle_o   <= 1'b1;
            dataStrobe_o <= 1'b0;
            stuffError_o <= 1'b0;
        end else begin
            dataStrobe_o <= 1'b0;
            stuffError_o <= 1'b0;
            if (bitStrobe_i) begin
                if (rxBit_i.se0) begin
                    prevLevelQ <= 1'b1;
                    onesQ      <= '0;
                    se0SeenQ   <= 1'b1;
                end else begin
                    prevLevelQ <= rxBit_i.value;
                    if (se0SeenQ) begin
                        se0SeenQ   <= 1'b0;
                        lineIdle_o <= 1'b1;
                    end else if (lineIdle_o) begin
                        // First K after idle is the first SYNC bit
                        if (!decoded) begin
                            lineIdle_o   <= 1'b0;
                            dataStrobe_o <= 1'b1;
                        end
                    end else if (onesQ == MaxOnes) begin
                        // Stuffed bit is dropped either way
                        onesQ        <= '0;
                        stuffError_o <= decoded;
                    end else begin
                        onesQ        <= decoded ? onesQ + 3'd1 : 3'd0;
                        dataStrobe_o <= 1'b1;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk48_i) begin
        if (bitStrobe_i) begin
            dataBit_o <= decoded;
        end
    end

endmodule

// File: rxByteAssembler.sv
// Hunts for SYNC, assembles received bytes LSB first and reports packet start and end
module rxByteAssembler
    import usbRxPkg::*;
(
    input  logic    clk48_i,
    input  logic    rstN_i,
    input  logic    dataStrobe_i,
    input  logic    dataBit_i,
    input  logic    lineIdle_i,
    input  logic    eopDetect_i,
    output logic    byteValid_o,
    output rxByte_t rxByte_o,
    output logic    packetStart_o,
    output logic    packetEnd_o,
    output logic    alignError_o
);

    // Seven zeros then a one, shifted in LSB first
    localparam logic [7:0] SyncPattern = 8'h80;

    typedef enum logic {
        HUNT,
        COLLECT
    } asmState_t;

    asmState_t  stateQ;
    logic [7:0] shiftQ;
    logic [7:0] shiftNext;
    logic [2:0] bitCountQ;
    logic       firstQ;
    logic       eopQ;
    logic       idleQ;
    logic       endEvent;
    logic       byteDone;

    assign shiftNext = {dataBit_i, shiftQ[7:1]};
    assign endEvent  = (eopDetect_i && !eopQ) || (lineIdle_i && !idleQ);
    assign byteDone  = (stateQ == COLLECT) && dataStrobe_i && !endEvent
                       && (bitCountQ == 3'd7);

    always_ff @(posedge clk48_i or negedge rstN_i) begin
        if (!rstN_i) begin
            stateQ        <= HUNT;
            shiftQ        <= 8'hFF;
            bitCountQ     <= '0;
            firstQ        <= 1'b0;
            eopQ          <= 1'b0;
            idleQ         <= 1'b1;
            byteValid_o   <= 1'b0;
            packetStart_o <= 1'b0;
            packetEnd_o   <= 1'b0;
            alignError_o  <= 1'b0;
        end else begin
            eopQ          <= eopDetect_i;
            idleQ         <= lineIdle_i;
            byteValid_o   <= byteDone;
            packetStart_o <= 1'b0;
            packetEnd_o   <= 1'b0;
            alignError_o  <= 1'b0;
            if (stateQ == HUNT) begin
                if (dataStrobe_i) begin
                    shiftQ <= shiftNext;
                    if (shiftNext == SyncPattern) begin
                        stateQ        <= COLLECT;
                        bitCountQ     <= '0;
                        firstQ        <= 1'b1;
                        packetStart_o <= 1'b1;
                    end
                end
            end else if (endEvent) begin
                // Leftover bits mean the packet did not end on a byte boundary
                stateQ       <= HUNT;
                shiftQ       <= 8'hFF;
                packetEnd_o  <= 1'b1;
                alignError_o <= (bitCountQ != 3'd0);
            end else if (dataStrobe_i) begin
                shiftQ    <= shiftNext;
                bitCountQ <= bitCountQ + 3'd1;
                if (byteDone) begin
                    firstQ <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk48_i) begin
        if (byteDone) begin
            rxByte_o.data  <= shiftNext;
            rxByte_o.first <= firstQ;
        end
    end

endmodule

// File: usbRxFrontend.sv
// Top level of the USB full-speed receive front end, joining sampler, detector and bit path
module usbRxFrontend
    import usbRxPkg::*;
(
    input  logic    clk48_i,
    input  logic    rstN_i,
    input  logic    dp_i,
    input  logic    dn_i,
    input  logic    ackEop_i,
    input  logic    ackUsbRst_i,
    output logic    eopDetect_o,
    output logic    usbRst_o,
    output logic    byteValid_o,
    output rxByte_t rxByte_o,
    output logic    packetStart_o,
    output logic    packetEnd_o,
    output logic    stuffError_o,
    output logic    alignError_o
);

    lineState_t line;
    logic       bitStrobe;
    rxBit_t     rxBit;
    logic       dataStrobe;
    logic       dataBit;
    logic       lineIdle;

    lineSampler i_lineSampler (
        .clk48_i (clk48_i),
        .rstN_i  (rstN_i),
        .dp_i    (dp_i),
        .dn_i    (dn_i),
        .line_o  (line)
    );

    eopResetDetect i_eopResetDetect (
        .clk48_i     (clk48_i),
        .rstN_i      (rstN_i),
        .line_i      (line),
        .ackEop_i    (ackEop_i),
        .ackUsbRst_i (ackUsbRst_i),
        .eopDetect_o (eopDetect_o),
        .usbRst_o    (usbRst_o)
    );

    clockRecovery i_clockRecovery (
        .clk48_i     (clk48_i),
        .rstN_i      (rstN_i),
        .line_i      (line),
        .bitStrobe_o (bitStrobe),
        .rxBit_o     (rxBit)
    );

    nrziUnstuff i_nrziUnstuff (
        .clk48_i      (clk48_i),
        .rstN_i       (rstN_i),
        .bitStrobe_i  (bitStrobe),
        .rxBit_i      (rxBit),
        .dataStrobe_o (dataStrobe),
        .dataBit_o    (dataBit),
        .stuffError_o (stuffError_o),
        .lineIdle_o   (lineIdle)
    );

    rxByteAssembler i_rxByteAssembler (
        .clk48_i       (clk48_i),
        .rstN_i        (rstN_i),
        .dataStrobe_i  (dataStrobe),
        .dataBit_i     (dataBit),
        .lineIdle_i    (lineIdle),
        .eopDetect_i   (eopDetect_o),
        .byteValid_o   (byteValid_o),
        .rxByte_o      (rxByte_o),
        .packetStart_o (packetStart_o),
        .packetEnd_o   (packetEnd_o),
        .alignError_o  (alignError_o)
    );

endmodule

// File: tbClockGen.sv
// Testbench clock and reset source for the receive front end, instantiated by the testbench top
module tbClockGen #(
    parameter int Period      = 40,
    parameter int ResetCycles = 8
) (
    output logic clk_o,
    output logic rstN_o
);

    initial begin
        clk_o = 1'b0;
        forever #(Period / 2) clk_o = ~clk_o;
    end

    // Reset is released on a falling edge, away from the sampling edge
    initial begin
        rstN_o = 1'b0;
        repeat (ResetCycles) @(posedge clk_o);
        @(negedge clk_o);
        rstN_o = 1'b1;
    end

endmodule

// File: usbRxTb.sv
// Directed testbench for the USB receive front end, encodes line waveforms and checks the outputs
`include "usbRx_defs.svh"

module usbRxTb
    import usbRxPkg::*;
();

    localparam int DriveDelay   = 5;
    localparam int ResetCycles  = 8;
    localparam int IdleBits     = 8;
    localparam int IdleGap      = 40;
    localparam int EndTimeout   = 200;
    localparam int PacketCycles = 400;
    localparam int NumPackets   = 5;
    localparam int Se0Cycles    = 100 + 140 + 6 * IdleGap;
    localparam int CycleLimit   = ResetCycles + NumPackets * PacketCycles + Se0Cycles + 1000;

    logic        clk48;
    logic        rstN;
    logic        dpDrv;
    logic        dnDrv;
    logic        ackEop;
    logic        ackUsbRst;
    logic        eopDetect;
    logic        usbRst;
    logic        byteValid;
    rxByte_t     rxByte;
    logic        packetStart;
    logic        packetEnd;
    logic        stuffError;
    logic        alignError;

    logic [31:0] seed = 32'h7257_db59;
    bit          rawQ[$];
    logic [7:0]  txQ[$];
    rxByte_t     expQ[$];
    rxByte_t     gotQ[$];
    int          startCount = 0;
    int          endCount = 0;
    int          stuffCount = 0;
    int          alignCount = 0;
    int          monitorErrors = 0;
    int          startBase;
    int          endBase;
    int          stuffBase;
    int          alignBase;
    int          byteBase;
    int          errorCount = 0;
    int          checkCount = 0;
    int          cycleCount = 0;

    tbClockGen #(.Period(40), .ResetCycles(ResetCycles)) i_clockGen (
        .clk_o  (clk48),
        .rstN_o (rstN)
    );

    usbRxFrontend i_dut (
        .clk48_i       (clk48),
        .rstN_i        (rstN),
        .dp_i          (dpDrv),
        .dn_i          (dnDrv),
        .ackEop_i      (ackEop),
        .ackUsbRst_i   (ackUsbRst),
        .eopDetect_o   (eopDetect),
        .usbRst_o      (usbRst),
        .byteValid_o   (byteValid),
        .rxByte_o      (rxByte),
        .packetStart_o (packetStart),
        .packetEnd_o   (packetEnd),
        .stuffError_o  (stuffError),
        .alignError_o  (alignError)
    );

    // Outputs are sampled on the falling edge, half a period after they change
    always @(negedge clk48) begin
        if (rstN) begin
            if (byteValid) gotQ.push_back(rxByte);
            if (packetStart) startCount++;
            if (packetEnd) endCount++;
            if (stuffError) stuffCount++;
            if (alignError) alignCount++;
            if (alignError && !packetEnd) begin
                monitorErrors++;
                $display("alignError_o pulsed without packetEnd_o at %0t", $time);
            end
        end
    end

    always @(posedge clk48) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CycleLimit) begin
            $display("Run stopped after %0d cycles before the tests finished", cycleCount);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [7:0] nextRandomByte();
        seed = xorshift32(seed);
        return seed[7:0];
    endfunction

    task automatic stepCycle();
        @(posedge clk48);
        #DriveDelay;
    endtask

    task automatic driveLine(input logic dp, input logic dn, input int cycles);
        repeat (cycles) begin
            stepCycle();
            dpDrv = dp;
            dnDrv = dn;
        end
    endtask

    task automatic expectEqual(input string what, input int got, input int exp);
        checkCount++;
        if (got != exp) begin
            errorCount++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic appendByte(input logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            rawQ.push_back(b[i]);
        end
    endtask

    // SYNC then the bytes, LSB first, with the expected list marking the PID
    task automatic buildPacket();
        rawQ.delete();
        expQ.delete();
        appendByte(8'h80);
        foreach (txQ[i]) begin
            rxByte_t e;
            e.first = (i == 0);
            e.data  = txQ[i];
            appendByte(txQ[i]);
            expQ.push_back(e);
        end
    endtask

    // NRZI from J, one stuffed zero after six ones, then two SE0 bits and idle J
    task automatic driveBits(input bit doStuff);
        logic level;
        int   ones;
        level = 1'b1;
        ones  = 0;
        foreach (rawQ[i]) begin
            if (!rawQ[i]) level = !level;
            driveLine(level, !level, `USB_SAMPLES_PER_BIT);
            ones = rawQ[i] ? ones + 1 : 0;
            if (doStuff && ones == `USB_MAX_ONES) begin
                level = !level;
                driveLine(level, !level, `USB_SAMPLES_PER_BIT);
                ones = 0;
            end
        end
        driveLine(1'b0, 1'b0, 2 * `USB_SAMPLES_PER_BIT);
        driveLine(1'b1, 1'b0, IdleBits * `USB_SAMPLES_PER_BIT);
    endtask

    task automatic markResults();
        startBase = startCount;
        endBase   = endCount;
        stuffBase = stuffCount;
        alignBase = alignCount;
        byteBase  = gotQ.size();
    endtask

    task automatic waitPacketEnd();
        int waited;
        waited = 0;
        while (endCount == endBase && waited < EndTimeout) begin
            stepCycle();
            waited++;
        end
        if (endCount == endBase) begin
            errorCount++;
            $display("No packetEnd_o pulse within %0d cycles at %0t", EndTimeout, $time);
        end
    endtask

    task automatic checkBytes();
        int got;
        got = gotQ.size() - byteBase;
        expectEqual("received byte count", got, expQ.size());
        for (int i = 0; i < expQ.size() && i < got; i++) begin
            checkCount++;
            if (gotQ[byteBase + i] !== expQ[i]) begin
                errorCount++;
                $display("Mismatch at %0t: byte %0d is %h, expected %h", $time, i,
                         gotQ[byteBase + i], expQ[i]);
            end
        end
    endtask

    task automatic checkPacket(input int expStuff, input int expAlign);
        checkBytes();
        expectEqual("packetStart_o pulses", startCount - startBase, 1);
        expectEqual("packetEnd_o pulses", endCount - endBase, 1);
        expectEqual("stuffError_o pulses", stuffCount - stuffBase, expStuff);
        expectEqual("alignError_o pulses", alignCount - alignBase, expAlign);
    endtask

    task automatic ackEopFlag();
        stepCycle();
        ackEop = 1'b1;
        stepCycle();
        ackEop = 1'b0;
        expectEqual("eopDetect_o after acknowledge", int'(eopDetect), 0);
    endtask

    task automatic sendPacket(input int expStuff);
        buildPacket();
        markResults();
        driveBits(1'b1);
        waitPacketEnd();
        checkPacket(expStuff, 0);
    endtask

    task automatic testBasicPacket();
        txQ.delete();
        txQ.push_back(8'hC3);
        repeat (4) txQ.push_back(nextRandomByte());
        sendPacket(0);
        ackEopFlag();
    endtask

    task automatic testBitStuffing();
        txQ.delete();
        txQ.push_back(8'h4B);
        txQ.push_back(8'hFF);
        txQ.push_back(8'h7F);
        txQ.push_back(8'hFF);
        sendPacket(0);
        ackEopFlag();
    endtask

    task automatic testStuffAndAlign();
        // Seven ones in a row counting the last SYNC bit, no stuffed zero
        rawQ.delete();
        appendByte(8'h80);
        appendByte(8'hFF);
        rawQ.push_back(1'b0);
        markResults();
        driveBits(1'b0);
        waitPacketEnd();
        expectEqual("stuffError_o pulses", stuffCount - stuffBase, 1);
        ackEopFlag();
        txQ.delete();
        txQ.push_back(8'hC3);
        buildPacket();
        rawQ.push_back(1'b1);
        rawQ.push_back(1'b0);
        rawQ.push_back(1'b1);
        markResults();
        driveBits(1'b1);
        waitPacketEnd();
        checkPacket(0, 1);
        ackEopFlag();
    endtask

    task automatic testEopFlag();
        txQ.delete();
        txQ.push_back(8'hD2);
        repeat (2) txQ.push_back(nextRandomByte());
        sendPacket(0);
        expectEqual("eopDetect_o after packet", int'(eopDetect), 1);
        driveLine(1'b1, 1'b0, IdleGap);
        expectEqual("eopDetect_o through idle", int'(eopDetect), 1);
        ackEopFlag();
        markResults();
        driveLine(1'b0, 1'b0, 2);
        driveLine(1'b1, 1'b0, IdleGap);
        expectEqual("eopDetect_o after SE0 glitch", int'(eopDetect), 0);
        expectEqual("packetStart_o after glitch", startCount - startBase, 0);
        expectEqual("packetEnd_o after glitch", endCount - endBase, 0);
    endtask

    task automatic testBusReset();
        markResults();
        driveLine(1'b0, 1'b0, 100);
        driveLine(1'b1, 1'b0, IdleGap);
        expectEqual("usbRst_o after short SE0", int'(usbRst), 0);
        ackEopFlag();
        driveLine(1'b0, 1'b0, 140);
        driveLine(1'b1, 1'b0, IdleGap);
        expectEqual("usbRst_o after long SE0", int'(usbRst), 1);
        driveLine(1'b1, 1'b0, IdleGap);
        expectEqual("usbRst_o through idle", int'(usbRst), 1);
        stepCycle();
        ackUsbRst = 1'b1;
        stepCycle();
        ackUsbRst = 1'b0;
        expectEqual("usbRst_o after acknowledge", int'(usbRst), 0);
        ackEopFlag();
        expectEqual("bytes during SE0", gotQ.size() - byteBase, 0);
        expectEqual("packetStart_o during SE0", startCount - startBase, 0);
    endtask

    initial begin
        dpDrv     = 1'b1;
        dnDrv     = 1'b0;
        ackEop    = 1'b0;
        ackUsbRst = 1'b0;
        @(posedge rstN);
        stepCycle();
        expectEqual("flags after reset", int'({eopDetect, usbRst, byteValid, packetStart,
                    packetEnd, stuffError, alignError}), 0);
        driveLine(1'b1, 1'b0, IdleGap);
        testBasicPacket();
        testBitStuffing();
        testStuffAndAlign();
        testEopFlag();
        testBusReset();
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount + monitorErrors);
        if (errorCount + monitorErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: project.f
+incdir+.
usbRxPkg.sv
lineSampler.sv
eopResetDetect.sv
clockRecovery.sv
nrziUnstuff.sv
rxByteAssembler.sv
usbRxFrontend.sv
tbClockGen.sv
usbRxTb.sv

// File: run.sh
#!/bin/sh
# Builds the receive front end testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 -f project.f --top-module usbRxTb -o usbRxSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/usbRxSim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qF '*** TEST PASSED ***'; then
    exit 0
fi
exit 1
